// ==== hw/dcache_pkg.sv ====
package dcache_pkg;

    // Address and word geometry
    parameter int addr_w = 32;
    parameter int word_w = 32;
    parameter int offset_w = 2;

    typedef enum logic {
        op_load,
        op_store
    } cache_op_e;

    // Controller states with st_init covering the tag RAM clear sweep
    typedef enum logic [2:0] {
        st_init,
        st_idle,
        st_lookup,
        st_writeback,
        st_refill,
        st_install,
        st_respond
    } ctrl_state_e;

endpackage

// ==== hw/spram.sv ====
`timescale 1ns/10ps

module spram #(
    parameter int WIDTH = 32,
    parameter int DEPTH = 16,
    parameter int BYTES = 4,
    parameter bit RESET = 0,
    localparam int idx_w = $clog2(DEPTH),
    localparam int lane_w = WIDTH / BYTES
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             en,
    input  logic [idx_w-1:0] addr,
    input  logic [BYTES-1:0] we,
    input  logic [WIDTH-1:0] wdata,
    output logic [WIDTH-1:0] rdata,
    output logic             ready
);

    logic [WIDTH-1:0] mem [DEPTH];
    logic [idx_w-1:0] sweep_cnt;
    logic             sweeping;

    // Clear sweep runs one word per cycle once rst drops
    always_ff @(posedge clk) begin
        if (rst) begin
            sweep_cnt <= '0;
            sweeping <= RESET;
            ready <= 1'b0;
        end else if (sweeping) begin
            sweep_cnt <= sweep_cnt + 1'b1;
            if (sweep_cnt == idx_w'(DEPTH - 1)) begin
                sweeping <= 1'b0;
                ready <= 1'b1;
            end
        end else begin
            ready <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (sweeping) begin
            mem[sweep_cnt] <= '0;
        end else begin
            for (int b = 0; b < BYTES; b++) begin
                if (we[b]) begin
                    mem[addr][b*lane_w +: lane_w] <= wdata[b*lane_w +: lane_w];
                end
            end
        end
        // Read returns the contents before any write in the same cycle
        if (en) begin
            rdata <= mem[addr];
        end
    end

endmodule

// ==== hw/dcache_data.sv ====
`timescale 1ns/10ps

module dcache_data import dcache_pkg::*; #(
    parameter int WAYS = 2,
    parameter int SETS = 16,
    parameter int BANKS = 2,
    localparam int idx_w = $clog2(SETS),
    localparam int bank_w = $clog2(BANKS),
    localparam int tag_w = addr_w - idx_w - bank_w - offset_w,
    localparam int byte_n = word_w / 8
) (
    input  logic                                  clk,
    input  logic                                  rst,
    input  logic [1:0]                            tagv_en,
    input  logic [WAYS-1:0]                       tagv_we,
    input  logic [1:0][idx_w-1:0]                 tagv_index,
    input  logic [tag_w:0]                        tagv_wdata,
    output logic [1:0][WAYS-1:0][tag_w:0]         tagv,
    output logic                                  tagv_ready,
    input  logic [BANKS-1:0]                      en,
    input  logic [BANKS-1:0][WAYS*byte_n-1:0]     we,
    input  logic [BANKS-1:0][idx_w-1:0]           index,
    input  logic [BANKS-1:0][idx_w-1:0]           windex,
    input  logic [BANKS-1:0][word_w-1:0]          wdata,
    output logic [BANKS-1:0][WAYS-1:0][word_w-1:0] data,
    input  logic                                  dirty_en,
    input  logic [idx_w-1:0]                      dirty_index,
    input  logic [WAYS-1:0]                       dirty_we,
    input  logic [idx_w-1:0]                      dirty_windex,
    input  logic [WAYS-1:0]                       dirty_wdata,
    output logic [WAYS-1:0]                       dirty
);

    logic [1:0]      tag_ready;
    logic [WAYS-1:0] dirty_bits [SETS];

    // Port 0 serves lookup and port 1 the victim while both take every tag write
    for (genvar p = 0; p < 2; p++) begin : g_tagv
        spram #(
            .WIDTH(WAYS * (tag_w + 1)),
            .DEPTH(SETS),
            .BYTES(WAYS),
            .RESET(1)
        ) tagv_ram (
            .clk(clk),
            .rst(rst),
            .en(tagv_en[p]),
            .addr(tagv_index[p]),
            .we(tagv_we),
            .wdata({WAYS{tagv_wdata}}),
            .rdata(tagv[p]),
            .ready(tag_ready[p])
        );
    end

    assign tagv_ready = &tag_ready;

    for (genvar b = 0; b < BANKS; b++) begin : g_bank
        logic [idx_w-1:0] bank_addr;

        assign bank_addr = |we[b] ? windex[b] : index[b];

        // Way is picked by which byte enables are set
        spram #(
            .WIDTH(WAYS * word_w),
            .DEPTH(SETS),
            .BYTES(WAYS * byte_n),
            .RESET(0)
        ) data_ram (
            .clk(clk),
            .rst(rst),
            .en(en[b]),
            .addr(bank_addr),
            .we(we[b]),
            .wdata({WAYS{wdata[b]}}),
            .rdata(data[b]),
            .ready()
        );
    end

    always_ff @(posedge clk) begin
        if (dirty_en) begin
            dirty <= dirty_bits[dirty_index];
        end
        for (int w = 0; w < WAYS; w++) begin
            if (dirty_we[w]) begin
                dirty_bits[dirty_windex][w] <= dirty_wdata[w];
            end
        end
    end

endmodule

// ==== hw/dcache_ctrl.sv ====
`timescale 1ns/10ps

module dcache_ctrl import dcache_pkg::*; #(
    parameter int WAYS = 2,
    parameter int SETS = 16,
    parameter int BANKS = 2,
    localparam int idx_w = $clog2(SETS),
    localparam int bank_w = $clog2(BANKS),
    localparam int way_w = $clog2(WAYS),
    localparam int tag_w = addr_w - idx_w - bank_w - offset_w,
    localparam int byte_n = word_w / 8
) (
    input  logic                                  clk,
    input  logic                                  rst,
    input  logic                                  req,
    input  cache_op_e                             op,
    input  logic [addr_w-1:0]                     addr,
    input  logic [word_w-1:0]                     wdata,
    input  logic [byte_n-1:0]                     byte_en,
    output logic                                  resp_valid,
    output logic [word_w-1:0]                     rdata,
    output logic                                  busy,
    output logic                                  mem_req,
    output logic                                  mem_we,
    output logic [addr_w-1:0]                     mem_addr,
    output logic [word_w-1:0]                     mem_wdata,
    input  logic                                  mem_ack,
    input  logic [word_w-1:0]                     mem_rdata,
    output logic [1:0]                            tagv_en,
    output logic [WAYS-1:0]                       tagv_we,
    output logic [1:0][idx_w-1:0]                 tagv_index,
    output logic [tag_w:0]                        tagv_wdata,
    input  logic [1:0][WAYS-1:0][tag_w:0]         tagv,
    input  logic                                  tagv_ready,
    output logic [BANKS-1:0]                      en,
    output logic [BANKS-1:0][WAYS*byte_n-1:0]     we,
    output logic [BANKS-1:0][idx_w-1:0]           index,
    output logic [BANKS-1:0][idx_w-1:0]           windex,
    output logic [BANKS-1:0][word_w-1:0]          bank_wdata,
    input  logic [BANKS-1:0][WAYS-1:0][word_w-1:0] data,
    output logic                                  dirty_en,
    output logic [idx_w-1:0]                      dirty_index,
    output logic [WAYS-1:0]                       dirty_we,
    output logic [idx_w-1:0]                      dirty_windex,
    output logic [WAYS-1:0]                       dirty_wdata,
    input  logic [WAYS-1:0]                       dirty
);

    ctrl_state_e state;

    cache_op_e           op_q;
    logic [addr_w-1:0]   addr_q;
    logic [word_w-1:0]   wdata_q;
    logic [byte_n-1:0]   be_q;
    logic [tag_w-1:0]    tag_q;
    logic [idx_w-1:0]    set_q;
    logic [bank_w-1:0]   bank_q;

    logic [way_w-1:0]    rr_ptr [SETS];
    logic [way_w-1:0]    hit_way;
    logic [way_w-1:0]    hit_way_q;
    logic [way_w-1:0]    victim;
    logic [way_w-1:0]    victim_q;
    logic [tag_w-1:0]    victim_tag_q;
    logic [word_w-1:0]   line_buf [BANKS];
    logic [bank_w-1:0]   bank_cnt;
    logic                hit;
    logic                victim_dirty;
    logic                mem_pend;
    logic                lookup_wait;
    logic                rd_go;
    logic [idx_w-1:0]    rd_set;

    assign tag_q  = addr_q[addr_w-1 -: tag_w];
    assign set_q  = addr_q[offset_w + bank_w +: idx_w];
    assign bank_q = addr_q[offset_w +: bank_w];

    // Array read happens on an accepted req and again after install
    assign rd_go  = (state == st_idle && req) || (state == st_lookup && lookup_wait);
    assign rd_set = (state == st_idle) ? addr[offset_w + bank_w +: idx_w] : set_q;

    assign tagv_en     = {2{rd_go}};
    assign tagv_index  = {2{rd_set}};
    assign tagv_wdata  = {1'b1, tag_q};
    assign en          = {BANKS{rd_go}};
    assign dirty_en    = rd_go;
    assign dirty_index = rd_set;
    assign dirty_windex = set_q;

    always_comb begin
        for (int b = 0; b < BANKS; b++) begin
            index[b] = rd_set;
            windex[b] = set_q;
        end
    end

    always_comb begin
        hit = 1'b0;
        hit_way = '0;
        for (int w = 0; w < WAYS; w++) begin
            if (tagv[0][w][tag_w] && tagv[0][w][tag_w-1:0] == tag_q) begin
                hit = 1'b1;
                hit_way = way_w'(w);
            end
        end
    end

    assign victim = rr_ptr[set_q];
    assign victim_dirty = tagv[1][victim][tag_w] && dirty[victim];

    assign busy       = state != st_idle;
    assign resp_valid = state == st_respond;
    // Bank outputs hold from the lookup read through the response cycle
    assign rdata      = data[bank_q][hit_way_q];

    assign mem_req   = (state == st_writeback || state == st_refill) && !mem_pend;
    assign mem_we    = state == st_writeback;
    assign mem_addr  = {mem_we ? victim_tag_q : tag_q, set_q, bank_cnt, offset_w'(0)};
    assign mem_wdata = line_buf[bank_cnt];

    always_comb begin
        tagv_we = '0;
        we = '0;
        bank_wdata = '0;
        dirty_we = '0;
        dirty_wdata = '0;
        case (state)
            st_install: begin
                // Whole line goes in and the way starts clean
                tagv_we[victim_q] = 1'b1;
                dirty_we[victim_q] = 1'b1;
                for (int b = 0; b < BANKS; b++) begin
                    we[b][victim_q*byte_n +: byte_n] = '1;
                    bank_wdata[b] = line_buf[b];
                end
            end
            st_respond: begin
                if (op_q == op_store) begin
                    we[bank_q][hit_way_q*byte_n +: byte_n] = be_q;
                    bank_wdata[bank_q] = wdata_q;
                    dirty_we[hit_way_q] = 1'b1;
                    dirty_wdata[hit_way_q] = 1'b1;
                end
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= st_init;
            mem_pend <= 1'b0;
            bank_cnt <= '0;
            lookup_wait <= 1'b0;
            for (int s = 0; s < SETS; s++) begin
                rr_ptr[s] <= '0;
            end
        end else begin
            case (state)
                st_init: if (tagv_ready) state <= st_idle;
                st_idle: if (req) state <= st_lookup;
                st_lookup: begin
                    if (lookup_wait) begin
                        lookup_wait <= 1'b0;
                    end else if (hit) begin
                        state <= st_respond;
                    end else if (victim_dirty) begin
                        state <= st_writeback;
                    end else begin
                        state <= st_refill;
                    end
                end
                st_writeback, st_refill: begin
                    if (mem_req) begin
                        mem_pend <= 1'b1;
                    end
                    if (mem_ack) begin
                        mem_pend <= 1'b0;
                        bank_cnt <= bank_cnt + 1'b1;
                        if (bank_cnt == bank_w'(BANKS - 1)) begin
                            state <= (state == st_writeback) ? st_refill : st_install;
                        end
                    end
                end
                st_install: begin
                    rr_ptr[set_q] <= victim_q + 1'b1;
                    lookup_wait <= 1'b1;
                    state <= st_lookup;
                end
                st_respond: state <= st_idle;
                default: state <= st_init;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == st_idle && req) begin
            op_q <= op;
            addr_q <= addr;
            wdata_q <= wdata;
            be_q <= byte_en;
        end
        if (state == st_lookup && !lookup_wait) begin
            hit_way_q <= hit_way;
            victim_q <= victim;
            victim_tag_q <= tagv[1][victim][tag_w-1:0];
            for (int b = 0; b < BANKS; b++) begin
                line_buf[b] <= data[b][victim];
            end
        end
        if (state == st_refill && mem_ack) begin
            line_buf[bank_cnt] <= mem_rdata;
        end
    end

endmodule

// ==== hw/dcache_top.sv ====
`timescale 1ns/10ps

module dcache_top import dcache_pkg::*; #(
    parameter int WAYS = 2,
    parameter int SETS = 16,
    parameter int BANKS = 2,
    localparam int idx_w = $clog2(SETS),
    localparam int bank_w = $clog2(BANKS),
    localparam int tag_w = addr_w - idx_w - bank_w - offset_w,
    localparam int byte_n = word_w / 8
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              req,
    input  cache_op_e         op,
    input  logic [addr_w-1:0] addr,
    input  logic [word_w-1:0] wdata,
    input  logic [byte_n-1:0] byte_en,
    output logic              resp_valid,
    output logic [word_w-1:0] rdata,
    output logic              busy,
    output logic              mem_req,
    output logic              mem_we,
    output logic [addr_w-1:0] mem_addr,
    output logic [word_w-1:0] mem_wdata,
    input  logic              mem_ack,
    input  logic [word_w-1:0] mem_rdata
);

    logic [1:0]                             tagv_en;
    logic [WAYS-1:0]                        tagv_we;
    logic [1:0][idx_w-1:0]                  tagv_index;
    logic [tag_w:0]                         tagv_wdata;
    logic [1:0][WAYS-1:0][tag_w:0]          tagv;
    logic                                   tagv_ready;
    logic [BANKS-1:0]                       en;
    logic [BANKS-1:0][WAYS*byte_n-1:0]      we;
    logic [BANKS-1:0][idx_w-1:0]            index;
    logic [BANKS-1:0][idx_w-1:0]            windex;
    logic [BANKS-1:0][word_w-1:0]           bank_wdata;
    logic [BANKS-1:0][WAYS-1:0][word_w-1:0] data;
    logic                                   dirty_en;
    logic [idx_w-1:0]                       dirty_index;
    logic [WAYS-1:0]                        dirty_we;
    logic [idx_w-1:0]                       dirty_windex;
    logic [WAYS-1:0]                        dirty_wdata;
    logic [WAYS-1:0]                        dirty;

    dcache_ctrl #(
        .WAYS(WAYS),
        .SETS(SETS),
        .BANKS(BANKS)
    ) ctrl_inst (
        .clk(clk),
        .rst(rst),
        .req(req),
        .op(op),
        .addr(addr),
        .wdata(wdata),
        .byte_en(byte_en),
        .resp_valid(resp_valid),
        .rdata(rdata),
        .busy(busy),
        .mem_req(mem_req),
        .mem_we(mem_we),
        .mem_addr(mem_addr),
        .mem_wdata(mem_wdata),
        .mem_ack(mem_ack),
        .mem_rdata(mem_rdata),
        .tagv_en(tagv_en),
        .tagv_we(tagv_we),
        .tagv_index(tagv_index),
        .tagv_wdata(tagv_wdata),
        .tagv(tagv),
        .tagv_ready(tagv_ready),
        .en(en),
        .we(we),
        .index(index),
        .windex(windex),
        .bank_wdata(bank_wdata),
        .data(data),
        .dirty_en(dirty_en),
        .dirty_index(dirty_index),
        .dirty_we(dirty_we),
        .dirty_windex(dirty_windex),
        .dirty_wdata(dirty_wdata),
        .dirty(dirty)
    );

    dcache_data #(
        .WAYS(WAYS),
        .SETS(SETS),
        .BANKS(BANKS)
    ) data_inst (
        .clk(clk),
        .rst(rst),
        .tagv_en(tagv_en),
        .tagv_we(tagv_we),
        .tagv_index(tagv_index),
        .tagv_wdata(tagv_wdata),
        .tagv(tagv),
        .tagv_ready(tagv_ready),
        .en(en),
        .we(we),
        .index(index),
        .windex(windex),
        .wdata(bank_wdata),
        .data(data),
        .dirty_en(dirty_en),
        .dirty_index(dirty_index),
        .dirty_we(dirty_we),
        .dirty_windex(dirty_windex),
        .dirty_wdata(dirty_wdata),
        .dirty(dirty)
    );

endmodule

// ==== dv/mem_model.sv ====
`timescale 1ns/10ps

module mem_model #(
    parameter int DEPTH = 1024,
    parameter int DELAY = 3,
    localparam int aw = $clog2(DEPTH)
) (
    input  logic        clk,
    input  logic        rst,
    input  logic        mem_req,
    input  logic        mem_we,
    input  logic [31:0] mem_addr,
    input  logic [31:0] mem_wdata,
    output logic        mem_ack,
    output logic [31:0] mem_rdata
);

    logic [31:0]   mem [DEPTH];
    logic          pending;
    logic          we_q;
    logic [aw-1:0] idx_q;
    logic [31:0]   wdata_q;
    int            wait_cnt;
    int            write_count;

    // Serves one access at a time with a fixed DELAY before the answer
    always @(posedge clk) begin
        if (rst) begin
            mem_ack <= 1'b0;
            pending <= 1'b0;
            write_count <= 0;
        end else begin
            mem_ack <= 1'b0;
            if (mem_req) begin
                pending <= 1'b1;
                wait_cnt <= DELAY - 1;
                we_q <= mem_we;
                idx_q <= mem_addr[aw+1:2];
                wdata_q <= mem_wdata;
            end else if (pending) begin
                if (wait_cnt == 0) begin
                    pending <= 1'b0;
                    mem_ack <= 1'b1;
                    if (we_q) begin
                        mem[idx_q] <= wdata_q;
                        write_count <= write_count + 1;
                    end else begin
                        mem_rdata <= mem[idx_q];
                    end
                end else begin
                    wait_cnt <= wait_cnt - 1;
                end
            end
        end
    end

endmodule

// ==== dv/dcache_tb.sv ====
`timescale 1ns/10ps

module dcache_tb import dcache_pkg::*; ();

    localparam int n_sets = 16;
    localparam int n_banks = 2;
    localparam int bank_w = $clog2(n_banks);
    localparam int line_shift = offset_w + bank_w;
    localparam int mem_depth = 1024;
    localparam int mem_aw = $clog2(mem_depth);
    localparam int mem_delay = 3;
    localparam int n_random = 200;
    localparam int n_requests = 9 + n_random;
    localparam int cycle_limit = 400 * n_requests + 1000;
    localparam int kind_any = 0;
    localparam int kind_hit = 1;
    localparam int kind_clean = 2;
    localparam int kind_dirty = 3;
    localparam logic [addr_w-1:0] evict_a = 32'h828;
    localparam logic [addr_w-1:0] set_stride = n_sets * n_banks * 4;

    logic              clk;
    logic              rst;
    logic              req;
    cache_op_e         op;
    logic [addr_w-1:0] addr;
    logic [word_w-1:0] wdata;
    logic [3:0]        byte_en;
    logic              resp_valid;
    logic [word_w-1:0] rdata;
    logic              busy;
    logic              mem_req;
    logic              mem_we;
    logic [addr_w-1:0] mem_addr;
    logic [word_w-1:0] mem_wdata;
    logic              mem_ack;
    logic [word_w-1:0] mem_rdata;

    // Reference memory follows every store the testbench issues
    logic [word_w-1:0] ref_mem [mem_depth];
    logic [31:0]       rng_state;
    string             test_name;
    cache_op_e         exp_op;
    logic [word_w-1:0] exp_rdata;
    int                exp_kind;
    int                cyc = 0;
    int                req_cyc;
    int                rd_cnt;
    int                wr_cnt;
    int                init_cnt;
    logic              init_done;
    logic              mem_out;
    logic              pending;
    logic [addr_w-1:0] req_line;

    always #10 clk = ~clk;

    dcache_top #(
        .WAYS(2),
        .SETS(n_sets),
        .BANKS(n_banks)
    ) dcache_top_inst (
        .clk(clk),
        .rst(rst),
        .req(req),
        .op(op),
        .addr(addr),
        .wdata(wdata),
        .byte_en(byte_en),
        .resp_valid(resp_valid),
        .rdata(rdata),
        .busy(busy),
        .mem_req(mem_req),
        .mem_we(mem_we),
        .mem_addr(mem_addr),
        .mem_wdata(mem_wdata),
        .mem_ack(mem_ack),
        .mem_rdata(mem_rdata)
    );

    mem_model #(
        .DEPTH(mem_depth),
        .DELAY(mem_delay)
    ) mem_inst (
        .clk(clk),
        .rst(rst),
        .mem_req(mem_req),
        .mem_we(mem_we),
        .mem_addr(mem_addr),
        .mem_wdata(mem_wdata),
        .mem_ack(mem_ack),
        .mem_rdata(mem_rdata)
    );

    function automatic logic [31:0] next_random();
        rng_state ^= rng_state << 13;
        rng_state ^= rng_state >> 17;
        rng_state ^= rng_state << 5;
        return rng_state;
    endfunction

    function automatic logic [31:0] merge_bytes(input logic [31:0] old_word,
                                                input logic [31:0] new_word,
                                                input logic [3:0] be);
        logic [31:0] merged;
        merged = old_word;
        for (int b = 0; b < 4; b++) begin
            if (be[b]) begin
                merged[8*b +: 8] = new_word[8*b +: 8];
            end
        end
        return merged;
    endfunction

    function automatic int word_index(input logic [addr_w-1:0] a);
        return int'(a[mem_aw+1:offset_w]);
    endfunction

    task automatic stop_run(input string what);
        $display("%s", what);
        $display(">>> FAIL");
        $fatal(1, "stopped at cycle %0d", cyc);
    endtask

    task automatic report_mismatch(input string what, input logic [31:0] expected,
                                   input logic [31:0] actual);
        $display("mismatch %s %s expected %h actual %h", test_name, what, expected, actual);
        stop_run("value check failed");
    endtask

    task automatic issue(input cache_op_e o, input logic [addr_w-1:0] a,
                         input logic [word_w-1:0] d, input logic [3:0] be,
                         input int kind, input string name);
        while (busy) @(negedge clk);
        test_name = name;
        exp_kind = kind;
        exp_op = o;
        if (o == op_load) begin
            exp_rdata = ref_mem[word_index(a)];
        end else begin
            ref_mem[word_index(a)] = merge_bytes(ref_mem[word_index(a)], d, be);
        end
        req = 1'b1;
        op = o;
        addr = a;
        wdata = d;
        byte_en = be;
        @(negedge clk);
        req = 1'b0;
        while (!resp_valid) @(negedge clk);
        @(negedge clk);
    endtask

    // Checks sample at the rising edge before the DUT updates
    always @(posedge clk) begin
        logic [addr_w-1:0] exp_addr;
        if (rst) begin
            init_cnt = 0;
            init_done = 1'b0;
            pending = 1'b0;
            mem_out = 1'b0;
            if (cyc > 0) begin
                assert (busy && !resp_valid && !mem_req)
                else stop_run("busy low or an output active during reset");
            end
        end else begin
            if (!init_done) begin
                assert (!resp_valid && !mem_req)
                else stop_run("output active before the tag RAM sweep finished");
                init_cnt++;
                assert (init_cnt <= n_sets + 4) else stop_run("busy did not fall after reset");
                init_done = !busy;
            end
            if (pending) begin
                assert (busy) else stop_run("busy low while a request was in flight");
            end
            if (req && !busy) begin
                pending = 1'b1;
                req_cyc = cyc;
                rd_cnt = 0;
                wr_cnt = 0;
                req_line = addr >> line_shift;
            end
            if (mem_req) begin
                assert (!mem_out) else stop_run("memory request while one was outstanding");
                assert (mem_addr < mem_depth * 4 && mem_addr[1:0] == 2'b00)
                else stop_run("memory address outside the model or not word aligned");
                if (mem_we) begin
                    assert (rd_cnt == 0) else stop_run("writeback after the refill started");
                    assert (mem_addr[offset_w +: bank_w] == wr_cnt)
                    else report_mismatch("writeback bank", wr_cnt, mem_addr[offset_w +: bank_w]);
                    assert (mem_wdata == ref_mem[word_index(mem_addr)])
                    else report_mismatch("writeback data", ref_mem[word_index(mem_addr)], mem_wdata);
                    wr_cnt++;
                end else begin
                    exp_addr = (req_line << line_shift) | addr_w'(rd_cnt << offset_w);
                    assert (mem_addr == exp_addr)
                    else report_mismatch("refill address", exp_addr, mem_addr);
                    rd_cnt++;
                end
                mem_out = 1'b1;
            end
            if (mem_ack) begin
                mem_out = 1'b0;
            end
            if (resp_valid) begin
                assert (pending) else stop_run("response without an accepted request");
                pending = 1'b0;
                if (exp_op == op_load) begin
                    assert (rdata == exp_rdata) else report_mismatch("rdata", exp_rdata, rdata);
                end
                assert (rd_cnt == 0 || rd_cnt == n_banks)
                else report_mismatch("refill count", n_banks, rd_cnt);
                assert (wr_cnt == 0 || (wr_cnt == n_banks && rd_cnt == n_banks))
                else report_mismatch("writeback count", n_banks, wr_cnt);
                if (rd_cnt == 0) begin
                    assert (cyc - req_cyc == 2)
                    else report_mismatch("hit latency", 2, cyc - req_cyc);
                end
                if (exp_kind == kind_hit) begin
                    assert (rd_cnt == 0) else report_mismatch("refill count", 0, rd_cnt);
                end
                if (exp_kind == kind_clean || exp_kind == kind_dirty) begin
                    assert (rd_cnt == n_banks)
                    else report_mismatch("refill count", n_banks, rd_cnt);
                    assert (wr_cnt == (exp_kind == kind_dirty ? n_banks : 0))
                    else report_mismatch("writeback count",
                                         exp_kind == kind_dirty ? n_banks : 0, wr_cnt);
                end
            end
        end
        cyc++;
        if (cyc >= cycle_limit) begin
            stop_run("timeout, the cycle limit was reached before the tests finished");
        end
    end

    initial begin
        int                wc_before;
        logic [31:0]       r;
        logic [addr_w-1:0] rnd_addr;
        rng_state = 32'd12;
        clk = 1'b0;
        rst = 1'b1;
        req = 1'b0;
        op = op_load;
        addr = '0;
        wdata = '0;
        byte_en = '0;
        test_name = "reset";
        exp_kind = kind_any;
        exp_op = op_load;
        exp_rdata = '0;
        for (int i = 0; i < mem_depth; i++) begin
            ref_mem[i] = next_random();
            mem_inst.mem[i] = ref_mem[i];
        end
        repeat (16) @(negedge clk);
        rst = 1'b0;

        issue(op_load, 32'h100, '0, '0, kind_clean, "load_miss");
        issue(op_load, 32'h104, '0, '0, kind_hit, "load_hit");
        issue(op_store, 32'h104, 32'ha5a5_5a5a, 4'b0101, kind_hit, "store_merge");
        issue(op_load, 32'h104, '0, '0, kind_hit, "store_merge");

        // Three lines in set 5 with two ways
        issue(op_load, evict_a, '0, '0, kind_clean, "evict_fill");
        issue(op_store, evict_a, 32'h1234_5678, 4'b0011, kind_hit, "evict_store");
        issue(op_load, evict_a + set_stride, '0, '0, kind_clean, "evict_fill");
        wc_before = mem_inst.write_count;
        issue(op_load, evict_a + 2 * set_stride, '0, '0, kind_dirty, "evict_dirty");
        assert (mem_inst.write_count - wc_before == n_banks)
        else report_mismatch("memory writes", n_banks, mem_inst.write_count - wc_before);
        wc_before = mem_inst.write_count;
        issue(op_load, evict_a, '0, '0, kind_clean, "evict_clean");
        assert (mem_inst.write_count == wc_before)
        else report_mismatch("memory writes", 0, mem_inst.write_count - wc_before);

        for (int n = 0; n < n_random; n++) begin
            r = next_random();
            rnd_addr = (addr_w'(r[5:0]) << line_shift) | (addr_w'(r[7 +: bank_w]) << offset_w);
            if (r[15]) begin
                issue(op_store, rnd_addr, next_random(), r[19:16], kind_any, "random_mix");
            end else begin
                issue(op_load, rnd_addr, '0, '0, kind_any, "random_mix");
            end
        end

        repeat (4) @(negedge clk);
        $display(">>> PASS");
        $finish;
    end

endmodule

// ==== dcache.f ====
hw/dcache_pkg.sv
hw/spram.sv
hw/dcache_data.sv
hw/dcache_ctrl.sv
hw/dcache_top.sv
dv/mem_model.sv
dv/dcache_tb.sv
